// ==== Makefile ====
# Verilator build and run for the datapath testbench

VERILATOR ?= verilator
TOP       ?= datapath_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard src/*.sv src/*.svh dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/datapath_props.sv ====
module datapath_props import cpu_types_pkg::*; (
   input logic  CLK,
   input logic  reset,
   input logic  imemREN,
   input logic  dmemREN,
   input logic  dmemWEN,
   input logic  dhit,
   input logic  halt,
   input word_t pc
);

   timeunit 1ns;
   timeprecision 1ps;

   no_dual_request: assert property (@(posedge CLK) disable iff (reset)
      !(dmemREN && dmemWEN))
      else $error("data read and write requested together");

   // fetch waits while a data access is open
   no_fetch_in_data: assert property (@(posedge CLK) disable iff (reset)
      !(imemREN && (dmemREN || dmemWEN)))
      else $error("instruction request during a data request");

   request_held: assert property (@(posedge CLK) disable iff (reset)
      ((dmemREN || dmemWEN) && !dhit) |=> $stable({dmemREN, dmemWEN}))
      else $error("data request dropped before dhit");

   pc_frozen: assert property (@(posedge CLK) disable iff (reset)
      halt |=> (halt && $stable(pc)))
      else $error("pc moved or halt dropped after halt");

endmodule

bind datapath datapath_props u_props (
   .CLK     (CLK),
   .reset   (reset),
   .imemREN (imemREN),
   .dmemREN (dmemREN),
   .dmemWEN (dmemWEN),
   .dhit    (dhit),
   .halt    (halt),
   .pc      (pc)
);

// ==== dv/datapath_tb.sv ====
`include "cpu_defines.svh"

module datapath_tb import cpu_types_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ROWS          = 30;
   localparam int N_PASSES        = 2;
   localparam int MEM_WORDS       = 64;
   localparam int RESET_CYCLES    = 8;
   localparam int HALT_CYCLES     = 20;
   localparam int WATCHDOG_CYCLES = N_PASSES * (N_ROWS * 10 + RESET_CYCLES + HALT_CYCLES);

   // one program row at address 4 * row
   typedef struct packed {
      word_t instr;
      logic  store;
      word_t saddr;
      word_t sdata;
      word_t next_pc;
   } row_t;

   typedef struct packed {
      word_t addr;
      word_t data;
   } mem_write_t;

   logic  CLK      = 1'b0;
   logic  reset    = 1'b1;
   logic  ihit     = 1'b0;
   logic  dhit     = 1'b0;
   word_t imemload = '0;
   word_t dmemload = '0;
   logic  imemREN;
   logic  dmemREN;
   logic  dmemWEN;
   logic  halt;
   word_t imemaddr;
   word_t dmemaddr;
   word_t dmemstore;

   row_t        prog [N_ROWS];
   word_t       imem [MEM_WORDS];
   word_t       dmem [MEM_WORDS];
   word_t       fetch_q [$];
   word_t       ref_fetch [$];
   mem_write_t  write_q [$];
   mem_write_t  ref_write [$];
   int          n_rows       = 0;
   int          checks       = 0;
   int          errors       = 0;
   int          iwait        = 0;
   int          dwait        = 0;
   logic        random_waits = 1'b0;
   logic [15:0] lfsr         = 16'd32;

   datapath u_dut (.*);

   always #5 CLK = ~CLK;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
   endfunction

   // 0 to 3 wait cycles from two lfsr bits
   function automatic int draw_wait();
      int w;
      w = 0;
      if (random_waits) begin
         repeat (2) begin
            lfsr = lfsr_next(lfsr);
            w = (w << 1) | int'(lfsr[0]);
         end
      end
      return w;
   endfunction

   function automatic word_t fill_word(input word_t addr);
      return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
   endfunction

   function automatic word_t rtype_word(input funct_e fn, input int rs, input int rt,
                                        input int rd, input int sh);
      return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic word_t itype_word(input opcode_e op, input int rs, input int rt,
                                        input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic word_t jump_word(input opcode_e op, input word_t target);
      return {op, target[27:2]};
   endfunction

   task automatic check_value(input string name, input word_t actual, input word_t expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic add_row(input word_t ins, input word_t nxt);
      prog[n_rows] = '{instr: ins, store: 1'b0, saddr: '0, sdata: '0, next_pc: nxt};
      n_rows++;
   endtask

   task automatic add_store(input word_t ins, input word_t sa, input word_t sd);
      prog[n_rows] = '{instr: ins, store: 1'b1, saddr: sa, sdata: sd,
                       next_pc: word_t'(4 * n_rows + 4)};
      n_rows++;
   endtask

   // expected values follow the mips rules by hand
   task automatic build_program();
      word_t skip;
      skip = itype_word(OP_SW, 0, 1, 32'h5C);
      add_row(itype_word(OP_ADDIU, 0, 1, 5), 32'h04);
      add_row(itype_word(OP_ADDIU, 0, 2, -3), 32'h08);
      add_row(itype_word(OP_LUI, 0, 3, 32'h1234), 32'h0C);
      add_row(itype_word(OP_ORI, 3, 3, 32'h5678), 32'h10);
      add_row(rtype_word(FN_SUBU, 1, 2, 4, 0), 32'h14);
      add_row(rtype_word(FN_SLT, 2, 1, 5, 0), 32'h18);
      add_row(rtype_word(FN_SLL, 0, 3, 6, 4), 32'h1C);
      add_row(itype_word(OP_XORI, 3, 7, 32'hFFFF), 32'h20);
      add_row(itype_word(OP_ADDIU, 0, 0, 7), 32'h24);
      add_store(itype_word(OP_SW, 0, 4, 32'h40), 32'h40, 32'h8);
      add_store(itype_word(OP_SW, 0, 5, 32'h44), 32'h44, 32'h1);
      add_store(itype_word(OP_SW, 0, 6, 32'h48), 32'h48, 32'h2345_6780);
      add_store(itype_word(OP_SW, 0, 7, 32'h4C), 32'h4C, 32'h1234_A987);
      add_store(itype_word(OP_SW, 0, 0, 32'h50), 32'h50, 32'h0);
      add_row(itype_word(OP_LW, 0, 8, 32'h80), 32'h3C);
      add_store(itype_word(OP_SW, 0, 8, 32'h54), 32'h54, fill_word(32'h80));
      add_row(itype_word(OP_BEQ, 1, 2, 9), 32'h44);
      add_row(itype_word(OP_BNE, 1, 1, 9), 32'h48);
      add_row(itype_word(OP_BEQ, 4, 4, 1), 32'h50);
      add_row(skip, '0);
      add_row(itype_word(OP_BNE, 1, 2, 1), 32'h58);
      add_row(skip, '0);
      add_row(jump_word(OP_JAL, 32'h68), 32'h68);
      add_row(jump_word(OP_J, 32'h74), 32'h74);
      add_row(skip, '0);
      add_row(skip, '0);
      add_store(itype_word(OP_SW, 0, 31, 32'h58), 32'h58, 32'h5C);
      add_row(rtype_word(FN_JR, 31, 0, 0, 0), 32'h5C);
      add_row(skip, '0);
      add_row(`CPU_HALT_WORD, '0);
   endtask

   // cache model answers a level request with a one-cycle hit
   always @(posedge CLK) begin : mem_model
      mem_write_t wr;
      ihit <= 1'b0;
      dhit <= 1'b0;
      if (reset) begin
         iwait = 0;
         dwait = 0;
         for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(word_t'(i * 4));
         end
      end else begin
         if (imemREN && !ihit) begin
            if (iwait == 0) begin
               ihit     <= 1'b1;
               imemload <= imem[imemaddr[7:2]];
               fetch_q.push_back(imemaddr);
               iwait = draw_wait();
            end else begin
               iwait--;
            end
         end
         if ((dmemREN || dmemWEN) && !dhit) begin
            if (dwait == 0) begin
               dhit     <= 1'b1;
               dmemload <= dmem[dmemaddr[7:2]];
               if (dmemWEN) begin
                  dmem[dmemaddr[7:2]] = dmemstore;
                  wr.addr = dmemaddr;
                  wr.data = dmemstore;
                  write_q.push_back(wr);
               end
               dwait = draw_wait();
            end else begin
               dwait--;
            end
         end
      end
   end

   // follow the fetches through the table until the halt word
   task automatic run_program(input int pass);
      word_t      addr;
      word_t      exp_pc;
      mem_write_t wr;
      mem_write_t ref_wr;
      row_t       row;
      int         n_fetch;
      int         n_write;
      exp_pc    = `CPU_PC_INIT;
      n_fetch   = 0;
      n_write   = 0;
      row.instr = '0;
      while (row.instr != `CPU_HALT_WORD) begin
         while (fetch_q.size() == 0) begin
            @(negedge CLK);
            if (n_fetch == 0) begin
               check_value("dmemREN | dmemWEN", word_t'(dmemREN | dmemWEN), '0);
            end
         end
         addr = fetch_q.pop_front();
         check_value("imemaddr", addr, exp_pc);
         check_value("pending stores", word_t'(write_q.size()), '0);
         if (pass == 0) begin
            ref_fetch.push_back(addr);
         end else begin
            check_value("fetch order", addr,
                        (n_fetch < ref_fetch.size()) ? ref_fetch[n_fetch] : '1);
         end
         n_fetch++;
         if (addr >= word_t'(4 * N_ROWS)) begin
            errors++;
            $display("fetch from %h lies outside the program table", addr);
            return;
         end
         row = prog[int'(addr[31:2])];
         if (row.store) begin
            while (write_q.size() == 0) begin
               @(negedge CLK);
            end
            wr = write_q.pop_front();
            check_value("dmemaddr", wr.addr, row.saddr);
            check_value("dmemstore", wr.data, row.sdata);
            if (pass == 0) begin
               ref_write.push_back(wr);
            end else begin
               ref_wr = (n_write < ref_write.size()) ? ref_write[n_write] : '1;
               check_value("store order addr", wr.addr, ref_wr.addr);
               check_value("store order data", wr.data, ref_wr.data);
            end
            n_write++;
         end
         exp_pc = row.next_pc;
      end
      while (!halt) begin
         @(negedge CLK);
      end
      repeat (HALT_CYCLES) begin
         @(negedge CLK);
         check_value("halt", word_t'(halt), 32'd1);
         check_value("imemREN", word_t'(imemREN), '0);
         check_value("fetches after halt", word_t'(fetch_q.size()), '0);
         check_value("stores after halt", word_t'(write_q.size()), '0);
      end
   endtask

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[i] = fill_word(word_t'(i * 4));
      end
      build_program();
      for (int i = 0; i < N_ROWS; i++) begin
         imem[i] = prog[i].instr;
      end
      // zero-wait pass first, then random wait states
      for (int pass = 0; pass < N_PASSES; pass++) begin
         random_waits = (pass != 0);
         @(posedge CLK);
         reset <= 1'b1;
         repeat (RESET_CYCLES) @(posedge CLK);
         reset <= 1'b0;
         run_program(pass);
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK);
      $display("timeout: the program did not reach its end within %0d cycles", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+src
src/cpu_types_pkg.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/pc_unit.sv
src/request_unit.sv
src/datapath.sv
dv/datapath_props.sv
dv/datapath_tb.sv

// ==== src/alu.sv ====
module alu import cpu_types_pkg::*; (
   input  word_t   op1,
   input  word_t   op2,
   input  alu_op_e opcode,
   input  shamt_t  shamt,
   output word_t   res,
   output logic    flag_z
);

   always_comb begin
      case (opcode)
         ALU_ADD:  res = op1 + op2;
         ALU_SUB:  res = op1 - op2;
         ALU_AND:  res = op1 & op2;
         ALU_OR:   res = op1 | op2;
         ALU_XOR:  res = op1 ^ op2;
         ALU_NOR:  res = ~(op1 | op2);
         // compares give 0 or 1
         ALU_SLT:  res = word_t'($signed(op1) < $signed(op2));
         ALU_SLTU: res = word_t'(op1 < op2);
         // shifts act on rt, as in mips
         ALU_SLL:  res = op2 << shamt;
         ALU_SRL:  res = op2 >> shamt;
         default:  res = '0;
      endcase
   end

   // beq/bne read this after a subtract
   assign flag_z = (res == '0);

endmodule

// ==== src/control_unit.sv ====
`include "cpu_defines.svh"

module control_unit import cpu_types_pkg::*; (
   input  word_t instr,
   output ctrl_t ctrl
);

   opcode_e opcode;
   funct_e  funct;

   assign opcode = opcode_e'(instr[31:26]);
   assign funct  = funct_e'(instr[5:0]);

   always_comb begin
      // fields pass through untouched
      ctrl.rs    = instr[25:21];
      ctrl.rt    = instr[20:16];
      ctrl.rd    = instr[15:11];
      ctrl.shamt = instr[10:6];
      ctrl.imm16 = instr[15:0];

      // no-op unless decoded below
      ctrl.alu_op    = ALU_ADD;
      ctrl.alu_src   = SRC_REG;
      ctrl.extop     = 1'b0;
      ctrl.regdst    = REGDST_RD;
      ctrl.regwr     = 1'b0;
      ctrl.memtoreg  = 1'b0;
      ctrl.link      = 1'b0;
      ctrl.dread     = 1'b0;
      ctrl.dwrite    = 1'b0;
      ctrl.pc_src    = PC_NEXT;
      ctrl.branch_ne = 1'b0;
      ctrl.halt      = 1'b0;

      if (instr == `CPU_HALT_WORD) begin
         ctrl.halt = 1'b1;
      end else begin
         case (opcode)
            OP_RTYPE: begin
               ctrl.regwr = 1'b1;
               case (funct)
                  FN_ADDU: ctrl.alu_op = ALU_ADD;
                  FN_SUBU: ctrl.alu_op = ALU_SUB;
                  FN_AND:  ctrl.alu_op = ALU_AND;
                  FN_OR:   ctrl.alu_op = ALU_OR;
                  FN_XOR:  ctrl.alu_op = ALU_XOR;
                  FN_NOR:  ctrl.alu_op = ALU_NOR;
                  FN_SLT:  ctrl.alu_op = ALU_SLT;
                  FN_SLTU: ctrl.alu_op = ALU_SLTU;
                  FN_SLL:  ctrl.alu_op = ALU_SLL;
                  FN_SRL:  ctrl.alu_op = ALU_SRL;
                  FN_JR: begin
                     ctrl.regwr  = 1'b0;
                     ctrl.pc_src = PC_REG;
                  end
                  default: ctrl.regwr = 1'b0;
               endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
               ctrl.alu_src = SRC_IMM_EXT;
               ctrl.regdst  = REGDST_RT;
               ctrl.regwr   = 1'b1;
               // only the arithmetic forms sign-extend
               ctrl.extop   = (opcode == OP_ADDIU) || (opcode == OP_SLTI);
               case (opcode)
                  OP_SLTI: ctrl.alu_op = ALU_SLT;
                  OP_ANDI: ctrl.alu_op = ALU_AND;
                  OP_ORI:  ctrl.alu_op = ALU_OR;
                  OP_XORI: ctrl.alu_op = ALU_XOR;
                  default: ctrl.alu_op = ALU_ADD;
               endcase
            end
            OP_LUI: begin
               // rs is zero in the encoding, so or just passes the upper half
               ctrl.alu_op  = ALU_OR;
               ctrl.alu_src = SRC_UPPER;
               ctrl.regdst  = REGDST_RT;
               ctrl.regwr   = 1'b1;
            end
            OP_LW: begin
               ctrl.alu_src  = SRC_IMM_EXT;
               ctrl.extop    = 1'b1;
               ctrl.regdst   = REGDST_RT;
               ctrl.regwr    = 1'b1;
               ctrl.memtoreg = 1'b1;
               ctrl.dread    = 1'b1;
            end
            OP_SW: begin
               ctrl.alu_src = SRC_IMM_EXT;
               ctrl.extop   = 1'b1;
               ctrl.dwrite  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
               // compare by subtraction, zero flag decides
               ctrl.alu_op    = ALU_SUB;
               ctrl.pc_src    = PC_BRANCH;
               ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_J: ctrl.pc_src = PC_JUMP;
            OP_JAL: begin
               ctrl.pc_src = PC_JUMP;
               ctrl.regdst = REGDST_LINK;
               ctrl.regwr  = 1'b1;
               ctrl.link   = 1'b1;
            end
            default: ctrl.regwr = 1'b0;
         endcase
      end
   end

endmodule

// ==== src/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and address width
`define CPU_WORD_W 32

// register index width, 32 registers
`define CPU_REG_ADDR_W 5

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// all-ones word stops the core
`define CPU_HALT_WORD 32'hFFFF_FFFF

// return address register written by jal
`define CPU_LINK_REG 5'd31

`endif

// ==== src/cpu_types_pkg.sv ====
`include "cpu_defines.svh"

package cpu_types_pkg;

   // plain vectors with a meaning
   typedef logic [`CPU_WORD_W-1:0]     word_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [15:0]                imm16_t;
   typedef logic [25:0]                imm26_t;
   typedef logic [4:0]                 shamt_t;

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0A,
      OP_ANDI  = 6'h0C,
      OP_ORI   = 6'h0D,
      OP_XORI  = 6'h0E,
      OP_LUI   = 6'h0F,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B
   } opcode_e;

   // r-type function codes
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_JR   = 6'h08,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2A,
      FN_SLTU = 6'h2B
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
   } alu_op_e;

   typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_REG} pc_src_e;
   typedef enum logic [1:0] {REGDST_RD, REGDST_RT, REGDST_LINK} regdst_e;
   typedef enum logic [1:0] {SRC_REG, SRC_IMM_EXT, SRC_UPPER} alu_src_e;

   // everything the decoder hands to the datapath
   typedef struct packed {
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      shamt_t    shamt;
      imm16_t    imm16;
      alu_op_e   alu_op;
      alu_src_e  alu_src;
      logic      extop;
      regdst_e   regdst;
      logic      regwr;
      logic      memtoreg;
      logic      link;
      logic      dread;
      logic      dwrite;
      pc_src_e   pc_src;
      logic      branch_ne;
      logic      halt;
   } ctrl_t;

endpackage

// ==== src/datapath.sv ====
`include "cpu_defines.svh"

module datapath import cpu_types_pkg::*; (
   input  logic  CLK,
   input  logic  reset,
   input  logic  ihit,
   input  logic  dhit,
   input  word_t imemload,
   input  word_t dmemload,
   output logic  imemREN,
   output logic  dmemREN,
   output logic  dmemWEN,
   output logic  halt,
   output word_t imemaddr,
   output word_t dmemaddr,
   output word_t dmemstore
);

   ctrl_t     ctrl;
   word_t     instr;
   word_t     rdat1;
   word_t     rdat2;
   word_t     alu_op2;
   word_t     alu_res;
   word_t     wdat;
   word_t     pc;
   word_t     pc_plus4;
   reg_addr_t wsel;
   logic      flag_z;
   logic      take_branch;
   logic      exec;
   logic      wreq;
   logic      pc_en;

   control_unit u_control (
      .instr (instr),
      .ctrl  (ctrl)
   );

   register_file u_regfile (
      .CLK   (CLK),
      .reset (reset),
      .wen   (wreq),
      .wsel  (wsel),
      .rsel1 (ctrl.rs),
      .rsel2 (ctrl.rt),
      .wdat  (wdat),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   alu u_alu (
      .op1    (rdat1),
      .op2    (alu_op2),
      .opcode (ctrl.alu_op),
      .shamt  (ctrl.shamt),
      .res    (alu_res),
      .flag_z (flag_z)
   );

   pc_unit u_pc (
      .CLK         (CLK),
      .reset       (reset),
      .en          (pc_en),
      .pc_src      (ctrl.pc_src),
      .take_branch (take_branch),
      .imm16       (ctrl.imm16),
      .imm26       (instr[25:0]),
      .rs_val      (rdat1),
      .pc          (pc),
      .pc_plus4    (pc_plus4)
   );

   request_unit u_request (
      .CLK      (CLK),
      .reset    (reset),
      .ihit     (ihit),
      .dhit     (dhit),
      .imemload (imemload),
      .dread    (ctrl.dread),
      .dwrite   (ctrl.dwrite),
      .regwr    (ctrl.regwr),
      .halt     (ctrl.halt),
      .instr    (instr),
      .exec     (exec),
      .imemREN  (imemREN),
      .dmemREN  (dmemREN),
      .dmemWEN  (dmemWEN),
      .wreq     (wreq),
      .pc_en    (pc_en)
   );

   // write select
   always_comb begin
      case (ctrl.regdst)
         REGDST_RT:   wsel = ctrl.rt;
         REGDST_LINK: wsel = `CPU_LINK_REG;
         default:     wsel = ctrl.rd;
      endcase
   end

   // write data, jal links the next address
   assign wdat = ctrl.memtoreg ? dmemload : (ctrl.link ? pc_plus4 : alu_res);

   // operand two, extender folded in
   always_comb begin
      case (ctrl.alu_src)
         SRC_IMM_EXT: alu_op2 = ctrl.extop ? {{16{ctrl.imm16[15]}}, ctrl.imm16}
                                           : {16'b0, ctrl.imm16};
         SRC_UPPER:   alu_op2 = {ctrl.imm16, 16'b0};
         default:     alu_op2 = rdat2;
      endcase
   end

   // bne takes the branch on a nonzero difference
   assign take_branch = flag_z ^ ctrl.branch_ne;

   assign imemaddr  = pc;
   assign dmemaddr  = alu_res;
   assign dmemstore = rdat2;
   assign halt      = ctrl.halt & exec;

endmodule

// ==== src/pc_unit.sv ====
`include "cpu_defines.svh"

module pc_unit import cpu_types_pkg::*; (
   input  logic    CLK,
   input  logic    reset,
   input  logic    en,
   input  pc_src_e pc_src,
   input  logic    take_branch,
   input  imm16_t  imm16,
   input  imm26_t  imm26,
   input  word_t   rs_val,
   output word_t   pc,
   output word_t   pc_plus4
);

   word_t branch_off;
   word_t pc_next;

   assign pc_plus4   = pc + word_t'(4);
   // word offset, sign-extended
   assign branch_off = {{14{imm16[15]}}, imm16, 2'b00};

   always_comb begin
      case (pc_src)
         PC_BRANCH: pc_next = take_branch ? (pc_plus4 + branch_off) : pc_plus4;
         PC_JUMP:   pc_next = {pc_plus4[31:28], imm26, 2'b00};
         PC_REG:    pc_next = rs_val;
         default:   pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         pc <= `CPU_PC_INIT;
      end else if (en) begin
         pc <= pc_next;
      end
   end

endmodule

// ==== src/register_file.sv ====
module register_file import cpu_types_pkg::*; (
   input  logic      CLK,
   input  logic      reset,
   input  logic      wen,
   input  reg_addr_t wsel,
   input  reg_addr_t rsel1,
   input  reg_addr_t rsel2,
   input  word_t     wdat,
   output word_t     rdat1,
   output word_t     rdat2
);

   word_t regs [2**$bits(reg_addr_t)];

   always_ff @(posedge CLK) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (wen && (wsel != '0)) begin
         // register zero never takes a write
         regs[wsel] <= wdat;
      end
   end

   // reads are combinational
   assign rdat1 = regs[rsel1];
   assign rdat2 = regs[rsel2];

endmodule

// ==== src/request_unit.sv ====
module request_unit import cpu_types_pkg::*; (
   input  logic  CLK,
   input  logic  reset,
   input  logic  ihit,
   input  logic  dhit,
   input  word_t imemload,
   input  logic  dread,
   input  logic  dwrite,
   input  logic  regwr,
   input  logic  halt,
   output word_t instr,
   output logic  exec,
   output logic  imemREN,
   output logic  dmemREN,
   output logic  dmemWEN,
   output logic  wreq,
   output logic  pc_en
);

   typedef enum logic [1:0] {IDLE, EXEC, DATA, HALTED} state_e;

   state_e state;
   state_e state_next;
   logic   mem_op;
   logic   data_phase;

   assign mem_op     = dread | dwrite;
   // data request is up from decode until dhit
   assign data_phase = (state == EXEC) || (state == DATA);

   assign imemREN = (state == IDLE);
   assign dmemREN = data_phase & dread;
   assign dmemWEN = data_phase & dwrite;
   // a halted core keeps the halt word as its current instruction
   assign exec    = (state == EXEC) || (state == HALTED);

   always_comb begin
      state_next = state;
      pc_en      = 1'b0;
      wreq       = 1'b0;
      case (state)
         IDLE: begin
            if (ihit) state_next = EXEC;
         end
         EXEC: begin
            if (halt) begin
               state_next = HALTED;
            end else if (!mem_op || dhit) begin
               pc_en      = 1'b1;
               wreq       = regwr;
               state_next = IDLE;
            end else begin
               state_next = DATA;
            end
         end
         DATA: begin
            // load data is valid in the dhit cycle
            if (dhit) begin
               pc_en      = 1'b1;
               wreq       = regwr;
               state_next = IDLE;
            end
         end
         HALTED: state_next = HALTED;
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // instruction register, stable through the data access
   always_ff @(posedge CLK) begin
      if ((state == IDLE) && ihit) begin
         instr <= imemload;
      end
   end

endmodule
